// ==== eeprom_ctrl_config.svh ====
`ifndef EEPROM_CTRL_CONFIG_SVH
`define EEPROM_CTRL_CONFIG_SVH

// CLK cycles per quarter of an SCL period
`define EEPROM_SCL_QTR 2

// register byte offsets
`define EEPROM_REG_CMD    4'h0
`define EEPROM_REG_ADDR   4'h4
`define EEPROM_REG_WDATA  4'h8
`define EEPROM_REG_STATUS 4'hC

// 1010 device type code of the 24C series
`define EEPROM_DEV_CODE 4'b1010

`endif

// ==== axil_bus_pkg.sv ====
`default_nettype none

package axil_bus_pkg;

    typedef enum logic [1:0]
    {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    typedef struct packed
    {
        logic [3:0] addr;
    } axil_aw_t;

    typedef struct packed
    {
        logic [31:0] data;
        logic [3:0]  strb;
    } axil_w_t;

    typedef struct packed
    {
        axil_resp_e resp;
    } axil_b_t;

    typedef struct packed
    {
        logic [3:0] addr;
    } axil_ar_t;

    typedef struct packed
    {
        logic [31:0] data;
        axil_resp_e  resp;
    } axil_r_t;

endpackage

`default_nettype wire

// ==== eeprom_ctrl_pkg.sv ====
`default_nettype none

package eeprom_ctrl_pkg;

    typedef enum logic [1:0]
    {
        OP_NONE  = 2'd0,
        OP_WRITE = 2'd1,
        OP_READ  = 2'd2
    } eeprom_op_e;

    typedef struct packed
    {
        eeprom_op_e  op;
        logic [10:0] addr;   // 10:8 go in the control byte
        logic [7:0]  wdata;
    } eeprom_cmd_t;

    typedef struct packed
    {
        logic       busy;
        logic       done;
        logic       nack;
        logic [7:0] rdata;
    } eeprom_status_t;

    // one-hot bus engine states
    typedef enum logic [7:0]
    {
        IDLE      = 8'h01,
        START     = 8'h02,
        SEND_BYTE = 8'h04,
        GET_ACK   = 8'h08,
        RESTART   = 8'h10,
        RECV_BYTE = 8'h20,
        SEND_NACK = 8'h40,
        STOP      = 8'h80
    } master_state_e;

endpackage

`default_nettype wire

// ==== eeprom_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "eeprom_ctrl_config.svh"

module eeprom_regs
    import axil_bus_pkg::*;
    import eeprom_ctrl_pkg::*;
(
    input  wire             CLK,
    input  wire             RESET,
    input  wire             awvalid,
    output logic            awready,
    input  wire axil_aw_t   aw,
    input  wire             wvalid,
    output logic            wready,
    input  wire axil_w_t    w,
    output logic            bvalid,
    input  wire             bready,
    output axil_b_t         b,
    input  wire             arvalid,
    output logic            arready,
    input  wire axil_ar_t   ar,
    output logic            rvalid,
    input  wire             rready,
    output axil_r_t         r,
    output logic            cmd_valid,
    output eeprom_cmd_t     cmd,
    input  wire             busy,
    input  wire             done,
    input  wire             nack,
    input  wire [7:0]       rdata
);
    logic [10:0]    addr_q;
    logic [7:0]     wdata_q;
    eeprom_status_t status_q;
    logic           wr_accept;
    logic           rd_accept;
    logic           launch;
    axil_resp_e     wr_resp;
    axil_resp_e     rd_resp;
    logic [31:0]    rd_data;
    logic           real_op;

    assign wr_accept = awvalid && wvalid && !bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign rd_accept = arvalid && !rvalid;
    assign arready   = rd_accept;

    assign real_op = (w.data[1:0] == OP_WRITE) || (w.data[1:0] == OP_READ);

    always_comb
    begin
        launch  = 1'b0;
        wr_resp = OKAY;
        case (aw.addr)
            `EEPROM_REG_CMD:
            begin
                if (w.data[1:0] == 2'b11)
                    wr_resp = SLVERR;   // no such opcode
                else if (real_op && (status_q.busy || busy))
                    wr_resp = SLVERR;
                else if (real_op)
                    launch = wr_accept;
            end
            `EEPROM_REG_ADDR, `EEPROM_REG_WDATA, `EEPROM_REG_STATUS:
                wr_resp = OKAY;
            default:
                wr_resp = SLVERR;
        endcase
    end

    always_comb
    begin
        rd_data = '0;
        rd_resp = OKAY;
        case (ar.addr)
            `EEPROM_REG_CMD:    rd_data = '0;  // write-only
            `EEPROM_REG_ADDR:   rd_data = {21'd0, addr_q};
            `EEPROM_REG_WDATA:  rd_data = {24'd0, wdata_q};
            `EEPROM_REG_STATUS: rd_data = {16'd0, status_q.rdata, 5'd0,
                                           status_q.nack, status_q.done, status_q.busy};
            default:            rd_resp = SLVERR;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            bvalid    <= 1'b0;
            rvalid    <= 1'b0;
            cmd_valid <= 1'b0;
            addr_q    <= '0;
            wdata_q   <= '0;
            status_q  <= '0;
        end
        else
        begin
            cmd_valid <= launch;
            if (bvalid && bready)
                bvalid <= 1'b0;
            if (wr_accept)
                bvalid <= 1'b1;
            if (rvalid && rready)
                rvalid <= 1'b0;
            if (rd_accept)
                rvalid <= 1'b1;
            if (wr_accept && aw.addr == `EEPROM_REG_ADDR)
            begin
                if (w.strb[0])
                    addr_q[7:0] <= w.data[7:0];
                if (w.strb[1])
                    addr_q[10:8] <= w.data[10:8];
            end
            if (wr_accept && aw.addr == `EEPROM_REG_WDATA && w.strb[0])
                wdata_q <= w.data[7:0];
            if (launch)
            begin
                status_q.busy <= 1'b1;
                status_q.done <= 1'b0;
                status_q.nack <= 1'b0;
            end
            else if (done)
            begin
                status_q.busy  <= 1'b0;
                status_q.done  <= 1'b1;   // sticky until next launch
                status_q.nack  <= nack;
                status_q.rdata <= rdata;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (wr_accept)
            b.resp <= wr_resp;
        if (rd_accept)
        begin
            r.data <= rd_data;
            r.resp <= rd_resp;
        end
        if (launch)
        begin
            cmd.op    <= eeprom_op_e'(w.data[1:0]);
            cmd.addr  <= addr_q;
            cmd.wdata <= wdata_q;
        end
    end

    a_bvalid_hold: assert property (@(posedge CLK) disable iff (RESET)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    // engine must be idle whenever a command leaves this block
    a_launch_idle: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> !busy)
        else $error("command launched while engine busy");

endmodule

`default_nettype wire

// ==== i2c_eeprom_master.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "eeprom_ctrl_config.svh"

module i2c_eeprom_master
    import eeprom_ctrl_pkg::*;
(
    input  wire              CLK,
    input  wire              RESET,
    input  wire              cmd_valid,
    input  wire eeprom_cmd_t cmd,
    output logic             busy,
    output logic             done,
    output logic             nack,
    output logic [7:0]       rdata,
    output logic             scl,
    output logic             sda_oe,
    input  wire              sda_in
);
    localparam int QTR = `EEPROM_SCL_QTR;
    localparam int QW  = $clog2(QTR + 1);

    master_state_e state;
    eeprom_cmd_t   cur;
    logic [QW-1:0] qtr_cnt;
    logic [1:0]    phase;       // 0 and 3 low, 1 and 2 high inside a bit
    logic [2:0]    bit_cnt;
    logic [1:0]    byte_idx;    // 0 ctrl wr, 1 word addr, 2 data, 3 ctrl rd
    logic [7:0]    shreg;
    logic          ack_in;
    logic          tick;
    logic          bit_end;
    logic          sample;
    logic          scl_cell;
    logic          start_ok;

    assign tick     = (state != IDLE) && (qtr_cnt == QW'(QTR - 1));
    assign bit_end  = tick && (phase == 2'd3);
    assign sample   = tick && (phase == 2'd1);   // end of first high quarter
    assign scl_cell = phase[0] ^ phase[1];
    assign start_ok = cmd_valid && (cmd.op == OP_WRITE || cmd.op == OP_READ);

    always_ff @(posedge CLK)
    begin
        if (RESET || state == IDLE)
        begin
            qtr_cnt <= '0;
            phase   <= 2'd0;
        end
        else if (tick)
        begin
            qtr_cnt <= '0;
            phase   <= phase + 2'd1;
        end
        else
            qtr_cnt <= qtr_cnt + 1'b1;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= IDLE;
            busy     <= 1'b0;
            done     <= 1'b0;
            nack     <= 1'b0;
            rdata    <= '0;
            bit_cnt  <= '0;
            byte_idx <= '0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                IDLE:
                    if (start_ok)
                    begin
                        busy     <= 1'b1;
                        nack     <= 1'b0;
                        bit_cnt  <= '0;
                        byte_idx <= 2'd0;
                        state    <= START;
                    end
                START, RESTART:
                    if (bit_end)
                        state <= SEND_BYTE;
                SEND_BYTE:
                    if (bit_end)
                    begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= GET_ACK;
                    end
                GET_ACK:
                    if (bit_end)
                    begin
                        if (ack_in)
                        begin
                            nack  <= 1'b1;   // abort straight to stop
                            state <= STOP;
                        end
                        else
                        begin
                            case (byte_idx)
                                2'd0:
                                begin
                                    byte_idx <= 2'd1;
                                    state    <= SEND_BYTE;
                                end
                                2'd1:
                                begin
                                    byte_idx <= (cur.op == OP_READ) ? 2'd3 : 2'd2;
                                    state    <= (cur.op == OP_READ) ? RESTART : SEND_BYTE;
                                end
                                2'd2:
                                    state <= STOP;
                                default:
                                    state <= RECV_BYTE;
                            endcase
                        end
                    end
                RECV_BYTE:
                    if (bit_end)
                    begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= SEND_NACK;
                    end
                SEND_NACK:
                    if (bit_end)
                    begin
                        rdata <= shreg;
                        state <= STOP;
                    end
                STOP:
                    if (bit_end)
                    begin
                        busy  <= 1'b0;
                        done  <= 1'b1;
                        state <= IDLE;
                    end
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == IDLE && start_ok)
        begin
            cur   <= cmd;
            shreg <= {`EEPROM_DEV_CODE, cmd.addr[10:8], 1'b0};
        end
        else if (state == SEND_BYTE && bit_end)
            shreg <= {shreg[6:0], 1'b0};
        else if (state == RECV_BYTE && sample)
            shreg <= {shreg[6:0], sda_in};
        else if (state == GET_ACK && bit_end)
            shreg <= (byte_idx == 2'd0) ? cur.addr[7:0] : cur.wdata;
        else if (state == RESTART && bit_end)
            shreg <= {`EEPROM_DEV_CODE, cur.addr[10:8], 1'b1};
        if (state == GET_ACK && sample)
            ack_in <= sda_in;   // high means no ack
    end

    always_comb
    begin
        scl    = 1'b1;
        sda_oe = 1'b0;
        case (state)
            START:
            begin
                scl    = (phase != 2'd3);
                sda_oe = phase[1];   // falls with scl high
            end
            RESTART:
            begin
                scl    = scl_cell;
                sda_oe = phase[1];
            end
            SEND_BYTE:
            begin
                scl    = scl_cell;
                sda_oe = ~shreg[7];
            end
            GET_ACK, RECV_BYTE, SEND_NACK:
                scl = scl_cell;
            STOP:
            begin
                scl    = (phase != 2'd0);
                sda_oe = ~phase[1];  // released with scl high
            end
            default:
            begin
                scl    = 1'b1;
                sda_oe = 1'b0;
            end
        endcase
    end

    a_sda_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && (sda_oe != $past(sda_oe)))
            |-> (state inside {START, RESTART, STOP}))
        else $error("sda_oe moved with scl high in state %s", state.name());

endmodule

`default_nettype wire

// ==== eeprom_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_top
    import axil_bus_pkg::*;
    import eeprom_ctrl_pkg::*;
(
    input  wire             CLK,
    input  wire             RESET,
    input  wire             awvalid,
    output logic            awready,
    input  wire axil_aw_t   aw,
    input  wire             wvalid,
    output logic            wready,
    input  wire axil_w_t    w,
    output logic            bvalid,
    input  wire             bready,
    output axil_b_t         b,
    input  wire             arvalid,
    output logic            arready,
    input  wire axil_ar_t   ar,
    output logic            rvalid,
    input  wire             rready,
    output axil_r_t         r,
    output logic            scl,
    output logic            sda_oe,
    input  wire             sda_in
);
    logic        cmd_valid;
    eeprom_cmd_t cmd;
    logic        busy;
    logic        done;
    logic        nack;
    logic [7:0]  rdata;

    eeprom_regs regs0 (
        .CLK(CLK), .RESET(RESET),
        .awvalid(awvalid), .awready(awready), .aw(aw),
        .wvalid(wvalid), .wready(wready), .w(w),
        .bvalid(bvalid), .bready(bready), .b(b),
        .arvalid(arvalid), .arready(arready), .ar(ar),
        .rvalid(rvalid), .rready(rready), .r(r),
        .cmd_valid(cmd_valid), .cmd(cmd),
        .busy(busy), .done(done), .nack(nack), .rdata(rdata)
    );

    // push-pull scl, open-drain sda split in two
    i2c_eeprom_master master0 (
        .CLK(CLK), .RESET(RESET),
        .cmd_valid(cmd_valid), .cmd(cmd),
        .busy(busy), .done(done), .nack(nack), .rdata(rdata),
        .scl(scl), .sda_oe(sda_oe), .sda_in(sda_in)
    );

endmodule

`default_nettype wire

// ==== tb_eeprom_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_model
(
    input  wire  scl,
    input  wire  sda,
    input  wire  silent,    // no acknowledge at all while set
    output logic sda_oe
);
    localparam int M_IDLE = 0;
    localparam int M_CTRL = 1;
    localparam int M_ADDR = 2;
    localparam int M_DATA = 3;
    localparam int M_SEND = 4;

    logic [7:0]  mem [0:2047];
    logic [10:0] ptr;
    logic [7:0]  sh;
    logic [7:0]  txbyte;
    int          mode;
    int          nbits;
    logic        give_ack;
    logic        in_ack;
    logic        scl_prev;
    logic        sda_prev;

    // low address byte with the block number folded into the top bits
    function automatic logic [7:0] fill_byte(input logic [10:0] a);
        return a[7:0] ^ {a[10:8], 5'd0};
    endfunction

    // silent only withholds the ack, write bytes that follow still land in mem
    task automatic byte_received();
        case (mode)
            M_CTRL:
                if (sh[7:4] == 4'b1010 && !(silent && sh[0]))
                begin
                    ptr[10:8] = sh[3:1];   // block select
                    give_ack  = !silent;
                    if (sh[0])
                    begin
                        txbyte = mem[ptr];
                        mode   = M_SEND;
                    end
                    else
                        mode = M_ADDR;
                end
                else
                    mode = M_IDLE;
            M_ADDR:
            begin
                ptr[7:0] = sh;
                give_ack = !silent;
                mode     = M_DATA;
            end
            M_DATA:
            begin
                mem[ptr] = sh;
                ptr[7:0] = ptr[7:0] + 8'd1;
                give_ack = !silent;
            end
            default:
                mode = M_IDLE;
        endcase
        nbits = 0;
    endtask

    task automatic scl_rise();
        if (!in_ack && (mode == M_CTRL || mode == M_ADDR || mode == M_DATA))
        begin
            sh    = {sh[6:0], sda};
            nbits = nbits + 1;
            if (nbits == 8)
                byte_received();
        end
        else if (!in_ack && mode == M_SEND)
        begin
            nbits = nbits + 1;
            if (nbits == 9)
                mode = M_IDLE;   // master ack slot ends the single byte
        end
    endtask

    task automatic scl_fall();
        if (give_ack)
        begin
            give_ack = 1'b0;
            in_ack   = 1'b1;
            sda_oe   = 1'b1;
        end
        else if (in_ack)
        begin
            in_ack = 1'b0;
            sda_oe = (mode == M_SEND) ? ~txbyte[7] : 1'b0;
        end
        else if (mode == M_SEND)
            sda_oe = (nbits < 8) ? ~txbyte[7 - nbits] : 1'b0;
    endtask

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = fill_byte(11'(i));
        mode     = M_IDLE;
        nbits    = 0;
        sh       = '0;
        txbyte   = '0;
        ptr      = '0;
        give_ack = 1'b0;
        in_ack   = 1'b0;
        sda_oe   = 1'b0;
        scl_prev = scl;
        sda_prev = sda;
        forever
        begin
            @(scl or sda);
            if (scl_prev === 1'b0 && scl === 1'b1)
                scl_rise();
            else if (scl_prev === 1'b1 && scl === 1'b0)
                scl_fall();
            else if (scl === 1'b1 && sda_prev === 1'b1 && sda === 1'b0)
            begin
                mode     = M_CTRL;   // start or repeated start
                nbits    = 0;
                give_ack = 1'b0;
                in_ack   = 1'b0;
                sda_oe   = 1'b0;
            end
            else if (scl === 1'b1 && sda_prev === 1'b0 && sda === 1'b1)
            begin
                mode     = M_IDLE;   // stop
                give_ack = 1'b0;
                in_ack   = 1'b0;
                sda_oe   = 1'b0;
            end
            scl_prev = scl;
            sda_prev = sda;
        end
    end

endmodule

`default_nettype wire

// ==== tb_eeprom_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "eeprom_ctrl_config.svh"

module tb_eeprom_ctrl
    import axil_bus_pkg::*;
    import eeprom_ctrl_pkg::*;
();
    localparam int HS_LIMIT   = 50;    // cycles per AXI handshake
    localparam int POLL_LIMIT = 500;   // STATUS reads per transfer

    logic        CLK;
    logic        RESET;
    logic        awvalid;
    logic        awready;
    axil_aw_t    aw;
    logic        wvalid;
    logic        wready;
    axil_w_t     w;
    logic        bvalid;
    logic        bready;
    axil_b_t     b;
    logic        arvalid;
    logic        arready;
    axil_ar_t    ar;
    logic        rvalid;
    logic        rready;
    axil_r_t     r;
    logic        scl;
    logic        sda_oe;
    logic        mem_sda_oe;
    logic        silent;
    wire         sda;
    logic [31:0] rng;
    logic [7:0]  shadow [0:2047];
    logic [7:0]  last_rd;   // rdata holds the last byte read

    assign sda = !(sda_oe || mem_sda_oe);   // pulled up unless either side pulls low

    eeprom_ctrl_top dut0 (
        .CLK(CLK), .RESET(RESET),
        .awvalid(awvalid), .awready(awready), .aw(aw),
        .wvalid(wvalid), .wready(wready), .w(w),
        .bvalid(bvalid), .bready(bready), .b(b),
        .arvalid(arvalid), .arready(arready), .ar(ar),
        .rvalid(rvalid), .rready(rready), .r(r),
        .scl(scl), .sda_oe(sda_oe), .sda_in(sda)
    );

    tb_eeprom_model model0 (.scl(scl), .sda(sda), .silent(silent), .sda_oe(mem_sda_oe));

    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [7:0] fill_byte(input logic [10:0] a);
        return a[7:0] ^ {a[10:8], 5'd0};
    endfunction

    // busy in bit 0, done in bit 1, nack in bit 2, rdata in 15:8
    function automatic eeprom_status_t to_status(input logic [31:0] d);
        return eeprom_status_t'({d[0], d[1], d[2], d[15:8]});
    endfunction

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        abort_run();
    endtask

    task automatic check_resp(input axil_resp_e got, input axil_resp_e exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s: response %b, expected %b", what, got, exp));
    endtask

    task automatic check_status(input eeprom_status_t got, input eeprom_status_t exp,
                                input string what);
        if (got !== exp)
            report_error($sformatf("%s: busy %b done %b nack %b rdata %h, expected %b %b %b %h",
                what, got.busy, got.done, got.nack, got.rdata,
                exp.busy, exp.done, exp.nack, exp.rdata));
    endtask

    task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              output axil_resp_e resp);
        int n;
        @(negedge CLK);
        awvalid = 1'b1;
        aw.addr = addr;
        wvalid  = 1'b1;
        w.data  = data;
        w.strb  = 4'hF;
        n = 0;
        @(posedge CLK);
        while (!(awready && wready))
        begin
            n = n + 1;
            if (n > HS_LIMIT)
                report_timeout("awready and wready");
            @(posedge CLK);
        end
        @(negedge CLK);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        n = 0;
        @(posedge CLK);
        while (!bvalid)
        begin
            n = n + 1;
            if (n > HS_LIMIT)
                report_timeout("bvalid");
            @(posedge CLK);
        end
        resp = b.resp;
        @(negedge CLK);
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                             output axil_resp_e resp);
        int n;
        @(negedge CLK);
        arvalid = 1'b1;
        ar.addr = addr;
        n = 0;
        @(posedge CLK);
        while (!arready)
        begin
            n = n + 1;
            if (n > HS_LIMIT)
                report_timeout("arready");
            @(posedge CLK);
        end
        @(negedge CLK);
        arvalid = 1'b0;
        rready  = 1'b1;
        n = 0;
        @(posedge CLK);
        while (!rvalid)
        begin
            n = n + 1;
            if (n > HS_LIMIT)
                report_timeout("rvalid");
            @(posedge CLK);
        end
        data = r.data;
        resp = r.resp;
        @(negedge CLK);
        rready = 1'b0;
    endtask

    task automatic write_expect(input logic [3:0] addr, input logic [31:0] data,
                                input axil_resp_e exp, input string what);
        axil_resp_e resp;
        axil_write(addr, data, resp);
        check_resp(resp, exp, what);
    endtask

    task automatic read_expect(input logic [3:0] addr, input logic [31:0] exp, input string what);
        logic [31:0] d;
        axil_resp_e  resp;
        axil_read(addr, d, resp);
        check_resp(resp, OKAY, what);
        check_data(d, exp, what);
    endtask

    task automatic wait_idle(output eeprom_status_t st);
        logic [31:0] d;
        axil_resp_e  resp;
        int          n;
        n = 0;
        axil_read(`EEPROM_REG_STATUS, d, resp);
        st = to_status(d);
        while (st.busy)
        begin
            n = n + 1;
            if (n > POLL_LIMIT)
                report_timeout("STATUS busy to clear");
            axil_read(`EEPROM_REG_STATUS, d, resp);
            st = to_status(d);
        end
        check_resp(resp, OKAY, "STATUS poll");
    endtask

    task automatic run_cmd(input eeprom_op_e op, input logic nack, input logic [7:0] rdata,
                           input string what);
        eeprom_status_t st;
        write_expect(`EEPROM_REG_CMD, 32'(op), OKAY, what);
        wait_idle(st);
        check_status(st, eeprom_status_t'({1'b0, 1'b1, nack, rdata}), what);
    endtask

    task automatic eeprom_write(input logic [10:0] a, input logic [7:0] d);
        write_expect(`EEPROM_REG_ADDR, {21'd0, a}, OKAY, "ADDR write");
        write_expect(`EEPROM_REG_WDATA, {24'd0, d}, OKAY, "WDATA write");
        run_cmd(OP_WRITE, 1'b0, last_rd, $sformatf("write to %h", a));
        shadow[a] = d;
        check_data({24'd0, model0.mem[a]}, {24'd0, d}, $sformatf("EEPROM byte %h", a));
    endtask

    task automatic eeprom_read(input logic [10:0] a);
        write_expect(`EEPROM_REG_ADDR, {21'd0, a}, OKAY, "ADDR write");
        run_cmd(OP_READ, 1'b0, shadow[a], $sformatf("read from %h", a));
        last_rd = shadow[a];
    endtask

    task automatic register_access();
        logic [31:0] d;
        axil_resp_e  resp;
        check_data({31'd0, scl}, 32'd1, "scl after reset");
        check_data({31'd0, sda_oe}, 32'd0, "sda_oe after reset");
        axil_read(`EEPROM_REG_STATUS, d, resp);
        check_resp(resp, OKAY, "STATUS read");
        check_data(d, 32'd0, "STATUS after reset");
        write_expect(`EEPROM_REG_ADDR, 32'hFFFF_FFFF, OKAY, "ADDR write");
        read_expect(`EEPROM_REG_ADDR, 32'h0000_07FF, "ADDR readback");
        write_expect(`EEPROM_REG_ADDR, 32'h0000_0123, OKAY, "ADDR write");
        read_expect(`EEPROM_REG_ADDR, 32'h0000_0123, "ADDR readback");
        write_expect(`EEPROM_REG_WDATA, 32'h0000_01A5, OKAY, "WDATA write");
        read_expect(`EEPROM_REG_WDATA, 32'h0000_00A5, "WDATA readback");
        read_expect(`EEPROM_REG_CMD, 32'd0, "CMD readback");
        write_expect(4'h2, 32'h1, SLVERR, "write to unmapped offset");
        axil_read(4'h6, d, resp);
        check_resp(resp, SLVERR, "read from unmapped offset");
    endtask

    task automatic write_then_read();
        logic [10:0] a;
        logic [7:0]  d;
        for (int i = 0; i < 8; i++)
        begin
            rng = xorshift32(rng);
            a   = rng[10:0];
            d   = rng[23:16];
            eeprom_write(a, d);
            eeprom_read(a);
        end
    endtask

    task automatic block_routing();
        logic [7:0] low;
        rng = xorshift32(rng);
        low = rng[7:0];
        for (int blk = 0; blk < 8; blk++)
            eeprom_write({3'(blk), low}, low ^ (8'h11 * 8'(blk + 1)));
        for (int blk = 0; blk < 8; blk++)
            eeprom_read({3'(blk), low});
    endtask

    task automatic missing_ack();
        logic [10:0] a;
        rng = xorshift32(rng);
        a   = rng[10:0];
        @(negedge CLK);
        silent = 1'b1;
        write_expect(`EEPROM_REG_ADDR, {21'd0, a}, OKAY, "ADDR write");
        write_expect(`EEPROM_REG_WDATA, {24'd0, ~shadow[a]}, OKAY, "WDATA write");
        run_cmd(OP_WRITE, 1'b1, last_rd, "write without acknowledge");
        check_data({24'd0, model0.mem[a]}, {24'd0, shadow[a]}, "EEPROM byte after nack");
        run_cmd(OP_READ, 1'b1, last_rd, "read without acknowledge");
        @(negedge CLK);
        silent = 1'b0;
        eeprom_read(a);
    endtask

    task automatic command_while_busy();
        eeprom_status_t st;
        logic [10:0]    a;
        logic [7:0]     d;
        rng = xorshift32(rng);
        a   = rng[10:0];
        d   = rng[23:16];
        write_expect(`EEPROM_REG_ADDR, {21'd0, a}, OKAY, "ADDR write");
        write_expect(`EEPROM_REG_WDATA, {24'd0, d}, OKAY, "WDATA write");
        write_expect(`EEPROM_REG_CMD, 32'(OP_WRITE), OKAY, "first command");
        write_expect(`EEPROM_REG_WDATA, {24'd0, ~d}, OKAY, "WDATA write while busy");
        write_expect(`EEPROM_REG_CMD, 32'(OP_WRITE), SLVERR, "command while busy");
        wait_idle(st);
        check_status(st, eeprom_status_t'({1'b0, 1'b1, 1'b0, last_rd}), "first command");
        shadow[a] = d;
        check_data({24'd0, model0.mem[a]}, {24'd0, d}, "EEPROM byte after refused command");
        eeprom_read(a);
    endtask

    task automatic unknown_opcode();
        logic [31:0] d;
        axil_resp_e  resp;
        write_expect(`EEPROM_REG_CMD, 32'(OP_NONE), OKAY, "OP_NONE command");
        axil_read(`EEPROM_REG_STATUS, d, resp);
        check_resp(resp, OKAY, "STATUS read");
        check_status(to_status(d), eeprom_status_t'({1'b0, 1'b1, 1'b0, last_rd}),
            "STATUS after OP_NONE");
    endtask

    initial
    begin
        RESET   = 1'b1;
        awvalid = 1'b0;
        aw      = '0;
        wvalid  = 1'b0;
        w       = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        ar      = '0;
        rready  = 1'b0;
        silent  = 1'b0;
        rng     = 32'h8870;
        last_rd = '0;
        for (int i = 0; i < 2048; i++)
            shadow[i] = fill_byte(11'(i));
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        register_access();
        write_then_read();
        block_routing();
        missing_ack();
        command_while_busy();
        unknown_opcode();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== eeprom_ctrl.f ====
+incdir+.
axil_bus_pkg.sv
eeprom_ctrl_pkg.sv
eeprom_regs.sv
i2c_eeprom_master.sv
eeprom_ctrl_top.sv
tb_eeprom_model.sv
tb_eeprom_ctrl.sv

// ==== Makefile ====
SRCS := $(filter %.sv,$(shell cat eeprom_ctrl.f)) eeprom_ctrl_config.svh

all: run

obj_dir/Vtb_eeprom_ctrl: eeprom_ctrl.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_eeprom_ctrl -f eeprom_ctrl.f

run: obj_dir/Vtb_eeprom_ctrl
	./obj_dir/Vtb_eeprom_ctrl

clean:
	rm -rf obj_dir

.PHONY: all run clean
